// ==== verification/encoder_cases.txt ====
# Columns: case name, operation (CW CCW HALF GLITCH), repeat count,
# expected value after the case
cw_small       CW      3   3
ccw_small      CCW     2   1
ccw_floor      CCW     4   0
half_at_zero   HALF    2   0
glitch_at_zero GLITCH  6   0
cw_45          CW      45  45
ccw_17         CCW     17  28
half_mid       HALF    3   28
glitch_mid     GLITCH  6   28
cw_to_top      CW      75  99
half_top       HALF    1   99
cw_over_top    CW      2   99
ccw_from_top   CCW     9   90
cw_one         CW      1   91

// ==== flist.f ====
design/encoder_pkg.sv
design/display_pkg.sv
design/input_debounce.sv
design/quadrature_decoder.sv
design/detent_counter.sv
design/display_scanner.sv
design/encoder_display_top.sv
verification/tb_clock_gen.sv
verification/encoder_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the encoder display testbench with Verilator and run it
set -e

verilator --binary --timing --assert -Wno-fatal \
   --top-module encoder_display_tb -f flist.f

out=$(./obj_dir/Vencoder_display_tb) || true
echo "$out"

# Pass only when the testbench reports it
echo "$out" | grep -q "TEST PASS"

// ==== verification/encoder_display_tb.sv ====
// Testbench for the encoder display chain
//  encoder_display_tb   reads cases from the case file, turns the
//                       encoder through the raw active low pins and
//                       checks both multiplexed digits of the display
//  Random hold times and glitch widths come from a 20-bit LFSR

module encoder_display_tb;

   logic                      clk_cyc;
   logic                      rst;
   encoder_pkg::quad_pins_t   enc_raw;
   display_pkg::display_out_t disp;

   // Reference digit patterns in A to G bit order
   localparam display_pkg::seg_pattern_t SEG_TABLE [10] = '{
      7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
      7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_1011
   };

   // Case table from the file
   string case_name [$];
   string case_op [$];
   int    case_count [$];
   int    case_exp [$];

   logic [19:0] lfsr_state;
   int          cycle_count;
   int          limit_cycles;
   int          model;

   tb_clock_gen clock_gen (
      .clk_cyc (clk_cyc),
      .rst     (rst)
   );

   encoder_display_top DUT (
      .clk_cyc (clk_cyc),
      .rst     (rst),
      .enc_raw (enc_raw),
      .disp    (disp)
   );

   // ------------------------------
   // Failure and compare tasks
   // ------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic compare_segments(input string name,
                                   input display_pkg::seg_pattern_t exp,
                                   input display_pkg::seg_pattern_t act);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %s segments expected %b actual %b", name, exp, act));
   endtask

   task automatic compare_digit_sel(input string name, input logic [1:0] exp,
                                    input logic [1:0] act);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %s digit_n expected %b actual %b", name, exp, act));
   endtask

   // ------------------------------
   // Random numbers
   // ------------------------------
   // Taps x^20 + x^17 + 1
   // One shift per bit taken
   function automatic logic [19:0] lfsr_step(input logic [19:0] s);
      lfsr_step = {s[18:0], s[19] ^ s[16]};
   endfunction

   function automatic int take_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = (v << 1) | {31'd0, lfsr_state[0]};
      end
      return v;
   endfunction

   // 8 to 15 cycles per quadrature state
   function automatic int hold_time();
      return 8 + take_bits(3);
   endfunction

   // ------------------------------
   // Encoder stimulus
   // ------------------------------
   // Arguments in clean polarity
   // Pins driven inverted
   task automatic hold_state(input logic a, input logic b, input int cycles);
      @(posedge clk_cyc);
      enc_raw.a <= ~a;
      enc_raw.b <= ~b;
      repeat (cycles - 1) @(posedge clk_cyc);
   endtask

   // Clockwise has a leading a
   task automatic turn_detent(input logic up);
      if (up) begin
         hold_state(1'b1, 1'b0, hold_time());
         hold_state(1'b1, 1'b1, hold_time());
         hold_state(1'b0, 1'b1, hold_time());
      end else begin
         hold_state(1'b0, 1'b1, hold_time());
         hold_state(1'b1, 1'b1, hold_time());
         hold_state(1'b1, 1'b0, hold_time());
      end
      hold_state(1'b0, 1'b0, hold_time());
   endtask

   // Two edges forward then back the same way
   task automatic half_turn();
      hold_state(1'b1, 1'b0, hold_time());
      hold_state(1'b1, 1'b1, hold_time());
      hold_state(1'b1, 1'b0, hold_time());
      hold_state(1'b0, 1'b0, hold_time());
   endtask

   // Short pulse on a or b below the filter window
   task automatic glitch_line();
      logic on_a;
      int   width;
      on_a  = take_bits(1) == 1;
      width = 1 + take_bits(1);
      hold_state(on_a, ~on_a, width);
      hold_state(1'b0, 1'b0, hold_time());
   endtask

   // ------------------------------
   // Display check
   // ------------------------------
   // Sampled on the falling edge away from register updates
   task automatic check_display(input string name, input int value);
      display_pkg::bcd_digit_t tens;
      display_pkg::bcd_digit_t ones;
      int waited;
      tens   = display_pkg::bcd_digit_t'(value / 10);
      ones   = display_pkg::bcd_digit_t'(value % 10);
      waited = 0;
      @(negedge clk_cyc);
      while (disp.digit_n !== 2'b01) begin
         waited++;
         if (waited > 3)
            abort_run($sformatf("Case %s: the tens digit was never selected", name));
         @(negedge clk_cyc);
      end
      compare_segments(name, SEG_TABLE[tens], disp.segments);
      // Ones must follow directly
      @(negedge clk_cyc);
      compare_digit_sel(name, 2'b10, disp.digit_n);
      compare_segments(name, SEG_TABLE[ones], disp.segments);
   endtask

   // ------------------------------
   // Case file
   // ------------------------------
   // Lines starting with # are comments
   task automatic load_cases();
      int    fd;
      int    n;
      string line;
      string name;
      string op;
      int    count;
      int    exp_val;
      fd = $fopen("verification/encoder_cases.txt", "r");
      if (fd == 0)
         abort_run("Could not open verification/encoder_cases.txt");
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         if (n > 0 && line.getc(0) != "#") begin
            if ($sscanf(line, "%s %s %d %d", name, op, count, exp_val) == 4) begin
               if (op != "CW" && op != "CCW" && op != "HALF" && op != "GLITCH")
                  abort_run($sformatf("Case %s has an unknown operation %s", name, op));
               case_name.push_back(name);
               case_op.push_back(op);
               case_count.push_back(count);
               case_exp.push_back(exp_val);
            end
         end
      end
      $fclose(fd);
      if (case_name.size() == 0)
         abort_run("The case file holds no cases");
   endtask

   // ------------------------------
   // Watchdog
   // ------------------------------
   always @(posedge clk_cyc) begin
      cycle_count <= cycle_count + 1;
      if (limit_cycles > 0 && cycle_count >= limit_cycles)
         abort_run($sformatf("Timeout after %0d cycles, the cases did not finish",
                             cycle_count));
   end

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      // Pins idle high with the encoder at rest
      enc_raw.a    = 1'b1;
      enc_raw.b    = 1'b1;
      lfsr_state   = 20'd84301;
      cycle_count  = 0;
      limit_cycles = 0;
      model        = 0;
      load_cases();
      // Worst case 15 cycles for each of 4 states per repeat
      limit_cycles = 200;
      foreach (case_count[i])
         limit_cycles += case_count[i] * 4 * 15;

      // Both cathodes off in the first cycle then strict alternation
      @(negedge clk_cyc);
      while (rst) @(negedge clk_cyc);
      compare_digit_sel("reset", 2'b11, disp.digit_n);
      for (int i = 0; i < 8; i++) begin
         @(negedge clk_cyc);
         compare_digit_sel("reset", (i % 2 == 0) ? 2'b01 : 2'b10, disp.digit_n);
      end
      check_display("reset", 0);

      foreach (case_name[i]) begin
         for (int r = 0; r < case_count[i]; r++) begin
            if (case_op[i] == "CW") begin
               turn_detent(1'b1);
               if (model < int'(encoder_pkg::COUNT_MAX))
                  model++;
            end else if (case_op[i] == "CCW") begin
               turn_detent(1'b0);
               if (model > 0)
                  model--;
            end else if (case_op[i] == "HALF") begin
               half_turn();
            end else begin
               glitch_line();
            end
         end
         // File and saturating model must agree
         if (case_exp[i] != model)
            abort_run($sformatf("[FAIL] %s file expected %0d actual model %0d",
                                case_name[i], case_exp[i], model));
         // Debounce, decoder, counter and scanner latency
         repeat (12) @(posedge clk_cyc);
         check_display(case_name[i], model);
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset
//  tb_clock_gen   period 100 clock, reset high for the first 3 cycles

module tb_clock_gen (
   output logic clk_cyc,
   output logic rst
);

   // Reset released on the third rising edge
   initial begin
      clk_cyc = 1'b0;
      rst     = 1'b1;
      repeat (3) @(posedge clk_cyc);
      rst <= 1'b0;
   end

   // Free running, half period of 50
   always #50 clk_cyc = ~clk_cyc;

endmodule

// ==== design/encoder_display_top.sv ====
// Rotary encoder to two digit display
//  encoder_display_top   debounce -> decoder -> counter -> scanner

module encoder_display_top (
   input  logic                      clk_cyc,
   input  logic                      rst,
   input  encoder_pkg::quad_pins_t   enc_raw,
   output display_pkg::display_out_t disp
);

   // Between the stages
   encoder_pkg::quad_pins_t enc_clean;
   encoder_pkg::step_t      step;
   encoder_pkg::count_t     value;

   // Raw active low pins in, clean active high lines out
   input_debounce u_debounce (
      .clk_cyc   (clk_cyc),
      .rst       (rst),
      .enc_raw   (enc_raw),
      .enc_clean (enc_clean)
   );

   // One step per full click
   quadrature_decoder u_decoder (
      .clk_cyc   (clk_cyc),
      .rst       (rst),
      .enc_clean (enc_clean),
      .step      (step)
   );

   // 0 .. 99 clamped count
   detent_counter u_counter (
      .clk_cyc (clk_cyc),
      .rst     (rst),
      .step    (step),
      .value   (value)
   );

   // Multiplexed two digit output
   display_scanner u_scanner (
      .clk_cyc (clk_cyc),
      .rst     (rst),
      .value   (value),
      .disp    (disp)
   );

endmodule

// ==== design/display_scanner.sv ====
// Two digit display driver
//  display_scanner   binary to BCD split, alternating digit scan,
//                    seven segment decode into registered outputs

module display_scanner (
   input  logic                      clk_cyc,
   input  logic                      rst,
   input  encoder_pkg::count_t       value,
   output display_pkg::display_out_t disp
);

   // Decimal digits of value
   display_pkg::bcd_digit_t tens;
   display_pkg::bcd_digit_t ones;

   // Digit routed to the segment decoder this cycle
   display_pkg::bcd_digit_t shown;

   // High while the tens digit is lit next
   logic scan_tens;

   // ------------------------------
   // Segment table
   // ------------------------------
   // Common cathode, bits A B C D E F G
   function automatic display_pkg::seg_pattern_t seg_decode(
      input display_pkg::bcd_digit_t digit
   );
      case (digit)
         4'd0:    seg_decode = 7'b111_1110;
         4'd1:    seg_decode = 7'b011_0000;
         4'd2:    seg_decode = 7'b110_1101;
         4'd3:    seg_decode = 7'b111_1001;
         4'd4:    seg_decode = 7'b011_0011;
         4'd5:    seg_decode = 7'b101_1011;
         4'd6:    seg_decode = 7'b101_1111;
         4'd7:    seg_decode = 7'b111_0000;
         4'd8:    seg_decode = 7'b111_1111;
         4'd9:    seg_decode = 7'b111_1011;
         default: seg_decode = display_pkg::SEG_BLANK;
      endcase
   endfunction

   // ------------------------------
   // Binary to BCD
   // ------------------------------
   // Nine conditional subtractions of ten cover 0 .. 99
   always_comb begin
      encoder_pkg::count_t rem;
      rem  = value;
      tens = '0;
      for (int i = 0; i < 9; i++) begin
         if (rem >= 8'd10) begin
            rem  = rem - 8'd10;
            tens = tens + 4'd1;
         end
      end
      ones = rem[3:0];
   end

   assign shown = scan_tens ? tens : ones;

   // ------------------------------
   // Scan and output registers
   // ------------------------------
   // Both cathodes off during reset, then tens first
   // Segments and cathode select load together
   always_ff @(posedge clk_cyc) begin
      if (rst) begin
         scan_tens     <= 1'b1;
         disp.segments <= display_pkg::SEG_BLANK;
         disp.digit_n  <= 2'b11;
      end else begin
         scan_tens     <= ~scan_tens;
         disp.segments <= seg_decode(shown);
         disp.digit_n  <= scan_tens ? 2'b01 : 2'b10;
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------
   // Never two cathodes at once once scanning has begun
   a_one_digit : assert property (
      @(posedge clk_cyc) disable iff (rst)
      !$past(rst) |-> $onehot(~disp.digit_n)
   );

endmodule

// ==== design/detent_counter.sv ====
// Detent counting
//  detent_counter   up/down counter driven by decoder steps,
//                   clamped to 0 .. COUNT_MAX

module detent_counter (
   input  logic                clk_cyc,
   input  logic                rst,
   input  encoder_pkg::step_t  step,
   output encoder_pkg::count_t value
);

   encoder_pkg::count_t value_next;

   logic at_top;
   logic at_bottom;

   // ------------------------------
   // Limits
   // ------------------------------
   assign at_top    = (value >= encoder_pkg::COUNT_MAX);
   assign at_bottom = (value == '0);

   // ------------------------------
   // Next value
   // ------------------------------
   // Hold unless a step arrives
   // Clockwise adds, counter clockwise subtracts
   // Stops dead at either end, no wrap
   always_comb begin
      value_next = value;
      if (step.valid) begin
         if (step.up) begin
            if (!at_top)
               value_next = value + 8'd1;
         end else begin
            if (!at_bottom)
               value_next = value - 8'd1;
         end
      end
   end

   // ------------------------------
   // Count register
   // ------------------------------
   // New value one cycle after the step pulse
   always_ff @(posedge clk_cyc) begin
      if (rst)
         value <= '0;
      else
         value <= value_next;
   end

   // ------------------------------
   // Checks
   // ------------------------------
   // Display converter only covers two digits
   a_value_range : assert property (
      @(posedge clk_cyc) disable iff (rst)
      value <= encoder_pkg::COUNT_MAX
   );

endmodule

// ==== design/quadrature_decoder.sv ====
// Quadrature decoding
//  quadrature_decoder   4x transition classifier with a signed
//                       accumulator, one step per full detent

module quadrature_decoder (
   input  logic                    clk_cyc,
   input  logic                    rst,
   input  encoder_pkg::quad_pins_t enc_clean,
   output encoder_pkg::step_t      step
);

   // State seen on the previous cycle
   encoder_pkg::quad_pins_t prev;

   // Signed count of transitions since the last rest
   logic signed [3:0] acc;
   logic signed [3:0] acc_next;

   logic changed;
   logic legal;
   logic forward;
   logic at_rest;
   logic in_range;
   logic full_turn;

   // ------------------------------
   // Transition classification
   // ------------------------------
   // Forward sequence, a then b: 00 -> 10 -> 11 -> 01 -> 00
   // Forward whenever the new b equals the old a
   always_comb begin
      changed   = (enc_clean != prev);
      legal     = (enc_clean.a ^ prev.a) ^ (enc_clean.b ^ prev.b);
      forward   = ~(prev.a ^ enc_clean.b);
      at_rest   = ~enc_clean.a & ~enc_clean.b;
      acc_next  = forward ? acc + 4'sd1 : acc - 4'sd1;
      in_range  = (acc_next <= encoder_pkg::DETENT_TRANSITIONS) &&
                  (acc_next >= -encoder_pkg::DETENT_TRANSITIONS);
      // Four edges the same way and back at rest
      full_turn = at_rest && legal &&
                  ((acc_next == encoder_pkg::DETENT_TRANSITIONS) ||
                   (acc_next == -encoder_pkg::DETENT_TRANSITIONS));
   end

   // ------------------------------
   // Accumulator and step pulse
   // ------------------------------
   always_ff @(posedge clk_cyc) begin
      if (rst) begin
         prev <= '0;
         acc  <= '0;
         step <= '0;
      end else begin
         prev       <= enc_clean;
         step.valid <= 1'b0;
         if (changed && at_rest) begin
            // Any arrival at rest starts a fresh detent
            acc <= '0;
            if (full_turn) begin
               step.valid <= 1'b1;
               step.up    <= (acc_next > 0);
            end
         end else if (legal && in_range) begin
            acc <= acc_next;
         end
         // Double jumps fall through untouched
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------
   // Steps are isolated pulses for the counter
   a_step_single : assert property (
      @(posedge clk_cyc) disable iff (rst)
      step.valid |=> !step.valid
   );

endmodule

// ==== design/input_debounce.sv ====
// Input conditioning for the quadrature lines
//  input_debounce   two flop synchronizer, polarity inversion and
//                   FILTER_DEPTH sample filter on each line

module input_debounce (
   input  logic                    clk_cyc,
   input  logic                    rst,
   input  encoder_pkg::quad_pins_t enc_raw,
   output encoder_pkg::quad_pins_t enc_clean
);

   // Synchronizer stages, already in positive logic
   encoder_pkg::quad_pins_t sync_1;
   encoder_pkg::quad_pins_t sync_2;

   // Older synchronized samples, newest in bit 0
   logic [encoder_pkg::FILTER_DEPTH-2:0] hist_a;
   logic [encoder_pkg::FILTER_DEPTH-2:0] hist_b;

   // Whole window, history plus current sample
   logic [encoder_pkg::FILTER_DEPTH-1:0] win_a;
   logic [encoder_pkg::FILTER_DEPTH-1:0] win_b;

   // ------------------------------
   // Synchronizer
   // ------------------------------
   // Pins idle high, so rest reads as zero after the flip
   always_ff @(posedge clk_cyc) begin
      if (rst) begin
         sync_1 <= '0;
         sync_2 <= '0;
      end else begin
         sync_1.a <= ~enc_raw.a;
         sync_1.b <= ~enc_raw.b;
         sync_2   <= sync_1;
      end
   end

   assign win_a = {hist_a, sync_2.a};
   assign win_b = {hist_b, sync_2.b};

   // ------------------------------
   // Sample filter
   // ------------------------------
   // Clean line moves only when the whole window agrees
   // Shorter bounces leave it where it was
   always_ff @(posedge clk_cyc) begin
      if (rst) begin
         hist_a    <= '0;
         hist_b    <= '0;
         enc_clean <= '0;
      end else begin
         hist_a <= win_a[encoder_pkg::FILTER_DEPTH-2:0];
         hist_b <= win_b[encoder_pkg::FILTER_DEPTH-2:0];
         if (&win_a)
            enc_clean.a <= 1'b1;
         else if (~|win_a)
            enc_clean.a <= 1'b0;
         if (&win_b)
            enc_clean.b <= 1'b1;
         else if (~|win_b)
            enc_clean.b <= 1'b0;
      end
   end

endmodule

// ==== design/display_pkg.sv ====
// Display side types and constants
//  bcd_digit_t     one decimal digit
//  seg_pattern_t   seven segment pattern, A in the top bit
//  display_out_t   segment lines plus digit enables
//  SEG_BLANK       all segments dark

package display_pkg;

   // ------------------------------
   // Digit value
   // ------------------------------
   // Only 0 to 9 are legal
   typedef logic [3:0] bcd_digit_t;

   // ------------------------------
   // Segment pattern
   // ------------------------------
   // Segment layout
   //     AAA
   //    F   B
   //     GGG
   //    E   C
   //     DDD
   // Bit 6 is A down to bit 0 is G
   // Common cathode, 1 lights a segment
   typedef logic [6:0] seg_pattern_t;

   // ------------------------------
   // Scan output
   // ------------------------------
   // digit_n is active low
   // Bit 1 drives the tens cathode, bit 0 the ones cathode
   // Segments always belong to the digit pulled low
   typedef struct packed {
      seg_pattern_t segments;
      logic [1:0]   digit_n;
   } display_out_t;

   // ------------------------------
   // Constants
   // ------------------------------
   // Nothing lit
   localparam seg_pattern_t SEG_BLANK = 7'b000_0000;

endpackage

// ==== design/encoder_pkg.sv ====
// Encoder side types and constants
//  quad_pins_t         one sample of the A/B quadrature lines
//  step_t              one accepted detent step
//  count_t             value handed to the display
//  FILTER_DEPTH        debounce window length
//  DETENT_TRANSITIONS  transitions per mechanical detent
//  COUNT_MAX           upper limit of the count

package encoder_pkg;

   // ------------------------------
   // Quadrature sample
   // ------------------------------
   // A leads B when turned clockwise
   // Raw pins active low, clean pins active high
   typedef struct packed {
      logic a;
      logic b;
   } quad_pins_t;

   // ------------------------------
   // Detent step
   // ------------------------------
   // Single cycle pulse on valid
   // up only meaningful while valid is high
   typedef struct packed {
      logic valid;
      logic up;
   } step_t;

   // Shown value, 0 to COUNT_MAX
   typedef logic [7:0] count_t;

   // ------------------------------
   // Constants
   // ------------------------------
   // Equal synchronized samples needed before a clean line moves
   localparam int FILTER_DEPTH = 3;

   // 4x decoding, four edges per click
   localparam int DETENT_TRANSITIONS = 4;

   // Saturation limit, two decimal digits
   localparam count_t COUNT_MAX = 8'd99;

endpackage
